//--- source/sata_config.svh
/*
    SATA DMA engine constants
    frame type codes, ATA command codes, frame lengths and identify positions
*/
`ifndef SATA_CONFIG_SVH
`define SATA_CONFIG_SVH

`default_nettype none

// frame type bytes, low byte of dword 0
`define SATA_FIS_REG_H2D        8'h27
`define SATA_FIS_REG_D2H        8'h34
`define SATA_FIS_PIO_SETUP      8'h5F
`define SATA_FIS_DATA           8'h46

// ATA commands
`define SATA_CMD_IDENTIFY       8'hEC
`define SATA_CMD_READ_DMA_EXT   8'h25

`define SATA_MAX_DMA_BURST      17'd65536   // sectors per READ DMA EXT
`define SATA_REG_H2D_DWORDS     5
`define SATA_ID_DWORDS          128         // identify payload, 512 bytes
`define SATA_ID_SATA_CAP_DW     38          // word 76 in low half
`define SATA_ID_MAX_LBA_DW      50          // words 100..103 in dw 50, 51
`define SATA_STATUS_ERR_BIT     0

`default_nettype wire

`endif

//--- source/sata_fis_pkg.sv
/*
    SATA link-side types
    stream beats, Register H2D request and first-dword decode
*/
`default_nettype none

package sata_fis_pkg;

    // received beat, one dword per cycle
    typedef struct packed {
        logic [31:0] dat;
        logic        val;
        logic        eop;   // last dword of frame
        logic        err;   // link error on this dword
    } fis_rx_beat_t;

    // transmitted beat
    typedef struct packed {
        logic [31:0] dat;
        logic        val;
        logic        eop;
    } fis_tx_beat_t;

    // fields of one Register H2D frame
    typedef struct packed {
        logic [7:0]  command;
        logic [47:0] lba;
        logic [15:0] count;    // 0 stands for 65536
    } reg_h2d_req_t;

    // dword 0 of any frame
    typedef union packed {
        struct packed {
            logic [23:0] rest;
            logic [7:0]  fis_type;
        } hdr;              // generic view
        struct packed {
            logic [7:0]  error;
            logic [7:0]  status;
            logic [7:0]  flags;
            logic [7:0]  fis_type;
        } reg_hdr;          // register / pio setup view
    } fis_dw0_u;

endpackage

`default_nettype wire

//--- source/sata_cmd_pkg.sv
/*
    SATA user-side types
    read command and device information
*/
`default_nettype none

package sata_cmd_pkg;

    // read command, sector units
    typedef struct packed {
        logic [47:0] addr;   // first lba
        logic [47:0] size;   // sector count, 0 is refused
    } usr_cmd_t;

    // results of identify
    typedef struct packed {
        logic [47:0] max_lba;
        logic [2:0]  sata_supported;  // gen3, gen2, gen1
    } usr_info_t;

endpackage

`default_nettype wire

//--- source/sata_reg_fis_sender.sv
/*
    Register H2D frame sender
    latches one request and serializes it into five dwords
*/
`include "sata_config.svh"

`default_nettype none

module sata_reg_fis_sender import sata_fis_pkg::*; (
    input  wire logic         i_usr_reset,   // clock
    input  wire logic         i_usr_clk,     // async reset, active high
    input  wire reg_h2d_req_t i_req,
    input  wire logic         i_req_val,
    output logic              o_req_rdy,
    output fis_tx_beat_t      o_tx,
    input  wire logic         i_tx_rdy
);

    localparam int CNT_W = $clog2(`SATA_REG_H2D_DWORDS);
    localparam logic [CNT_W-1:0] LAST_DW = CNT_W'(`SATA_REG_H2D_DWORDS - 1);

    reg_h2d_req_t     req_q;    // frame being sent
    logic             busy;
    logic [CNT_W-1:0] dw_cnt;   // current dword
    logic [31:0]      dw;

    assign o_req_rdy = ~busy;   // one frame at a time

    // ------------------------------------------------------------------------
    // dword layout
    always_comb begin
        case (dw_cnt)
            3'd0:    dw = {8'h00, req_q.command, 8'h80, `SATA_FIS_REG_H2D}; // C bit set
            3'd1:    dw = {8'h40, req_q.lba[23:0]};   // device: lba mode
            3'd2:    dw = {8'h00, req_q.lba[47:24]};
            3'd3:    dw = {16'h0000, req_q.count};
            default: dw = 32'h0000_0000;              // dword 4 reserved
        endcase
    end

    assign o_tx.dat = dw;
    assign o_tx.val = busy;
    assign o_tx.eop = busy & (dw_cnt == LAST_DW);

    // ------------------------------------------------------------------------
    // frame counter
    always_ff @(posedge i_usr_reset or posedge i_usr_clk) begin
        if (i_usr_clk) begin
            busy   <= 1'b0;
            dw_cnt <= '0;
        end else if (i_req_val & o_req_rdy) begin
            busy   <= 1'b1;   // first dword next cycle
            dw_cnt <= '0;
        end else if (busy & i_tx_rdy) begin
            if (dw_cnt == LAST_DW) begin
                busy   <= 1'b0;
                dw_cnt <= '0;
            end else begin
                dw_cnt <= dw_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge i_usr_reset) begin
        if (i_req_val & o_req_rdy)
            req_q <= i_req;
    end

endmodule

`default_nettype wire

//--- source/sata_fis_router.sv
/*
    Received frame router
    classifies frames by type, strips data headers and steers payload
    to the user read stream or the identify parser
*/
`include "sata_config.svh"

`default_nettype none

module sata_fis_router import sata_fis_pkg::*; (
    input  wire logic         i_usr_reset,   // clock
    input  wire logic         i_usr_clk,     // async reset, active high
    input  wire fis_rx_beat_t i_rx,
    output logic              o_rx_rdy,
    input  wire logic         i_id_select,   // data payload goes to parser
    output fis_rx_beat_t      o_rd,
    input  wire logic         i_rd_rdy,
    output fis_rx_beat_t      o_id,
    output logic              o_reg_done,    // pulse after reg frame eop
    output logic              o_reg_err
);

    typedef enum logic [1:0] {
        CLS_REG,     // register d2h or pio setup
        CLS_DATA,
        CLS_OTHER    // drained
    } frame_class_t;

    fis_dw0_u     dw0;
    frame_class_t hdr_class;   // class if this beat is a header
    frame_class_t class_q;     // class of frame in flight
    frame_class_t cur_class;
    logic         in_frame;    // header consumed
    logic         err_q;       // error seen so far in frame
    logic         err_now;
    logic         pay_data;    // data payload beat on input
    logic         fire;
    logic         reg_end;

    assign dw0 = i_rx.dat;

    // ------------------------------------------------------------------------
    // header decode
    always_comb begin
        case (dw0.hdr.fis_type)
            `SATA_FIS_REG_D2H,
            `SATA_FIS_PIO_SETUP: hdr_class = CLS_REG;
            `SATA_FIS_DATA:      hdr_class = CLS_DATA;
            default:             hdr_class = CLS_OTHER;
        endcase
    end

    assign cur_class = in_frame ? class_q : hdr_class;
    assign pay_data  = in_frame & (class_q == CLS_DATA);

    // only user payload sees back-pressure
    assign o_rx_rdy = (pay_data & ~i_id_select) ? i_rd_rdy : 1'b1;
    assign fire     = i_rx.val & o_rx_rdy;

    assign err_now = err_q | i_rx.err
                   | (~in_frame & (hdr_class == CLS_REG)
                      & dw0.reg_hdr.status[`SATA_STATUS_ERR_BIT]);
    assign reg_end = fire & i_rx.eop & (cur_class == CLS_REG);

    // payload outputs, header never passes
    assign o_rd.dat = i_rx.dat;
    assign o_rd.eop = i_rx.eop;
    assign o_rd.err = i_rx.err;
    assign o_rd.val = i_rx.val & pay_data & ~i_id_select;
    assign o_id.dat = i_rx.dat;
    assign o_id.eop = i_rx.eop;
    assign o_id.err = i_rx.err;
    assign o_id.val = i_rx.val & pay_data & i_id_select;

    // ------------------------------------------------------------------------
    // frame tracking
    always_ff @(posedge i_usr_reset or posedge i_usr_clk) begin
        if (i_usr_clk) begin
            in_frame   <= 1'b0;
            class_q    <= CLS_OTHER;
            err_q      <= 1'b0;
            o_reg_done <= 1'b0;
            o_reg_err  <= 1'b0;
        end else begin
            o_reg_done <= reg_end;
            o_reg_err  <= reg_end & err_now;
            if (fire) begin
                if (i_rx.eop) begin
                    in_frame <= 1'b0;   // next beat is a header
                    err_q    <= 1'b0;
                end else begin
                    in_frame <= 1'b1;
                    err_q    <= err_now;
                    if (!in_frame)
                        class_q <= hdr_class;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/sata_identify_parser.sv
/*
    Identify data parser
    picks max lba and supported SATA generations from the identify payload
*/
`include "sata_config.svh"

`default_nettype none

module sata_identify_parser import sata_fis_pkg::*, sata_cmd_pkg::*; (
    input  wire logic         i_usr_reset,   // clock
    input  wire logic         i_usr_clk,     // async reset, active high
    input  wire fis_rx_beat_t i_id,          // payload only, always accepted
    output logic              o_info_valid,
    output usr_info_t         o_info
);

    localparam int CNT_W = $clog2(`SATA_ID_DWORDS);
    localparam logic [CNT_W-1:0] CAP_DW    = CNT_W'(`SATA_ID_SATA_CAP_DW);
    localparam logic [CNT_W-1:0] LBA_LO_DW = CNT_W'(`SATA_ID_MAX_LBA_DW);
    localparam logic [CNT_W-1:0] LBA_HI_DW = CNT_W'(`SATA_ID_MAX_LBA_DW + 1);

    logic [CNT_W-1:0] dw_cnt;   // payload dword index

    // ------------------------------------------------------------------------
    // dword counter, valid flag
    always_ff @(posedge i_usr_reset or posedge i_usr_clk) begin
        if (i_usr_clk) begin
            dw_cnt       <= '0;
            o_info_valid <= 1'b0;
        end else if (i_id.val) begin
            if (i_id.eop) begin
                dw_cnt       <= '0;
                o_info_valid <= 1'b1;   // stays until reset
            end else begin
                dw_cnt <= dw_cnt + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // field capture
    always_ff @(posedge i_usr_reset) begin
        if (i_id.val) begin
            if (dw_cnt == CAP_DW)
                o_info.sata_supported <= i_id.dat[3:1];    // word 76 bits 3:1
            if (dw_cnt == LBA_LO_DW)
                o_info.max_lba[31:0] <= i_id.dat;          // words 100, 101
            if (dw_cnt == LBA_HI_DW)
                o_info.max_lba[47:32] <= i_id.dat[15:0];   // word 102
        end
    end

endmodule

`default_nettype wire

//--- source/sata_dma_sequencer.sv
/*
    DMA sequencer
    start-up identify sequence, then splits user reads into READ DMA EXT transfers
*/
`include "sata_config.svh"

`default_nettype none

module sata_dma_sequencer import sata_fis_pkg::*, sata_cmd_pkg::*; (
    input  wire logic        i_usr_reset,   // clock
    input  wire logic        i_usr_clk,     // async reset, active high
    input  wire logic        i_cmd_valid,
    input  wire usr_cmd_t    i_cmd,
    output logic             o_cmd_ready,
    output logic             o_cmd_fault,
    input  wire logic        i_info_valid,
    input  wire logic [47:0] i_max_lba,
    input  wire logic        i_reg_done,    // d2h / pio setup received
    input  wire logic        i_reg_err,
    output reg_h2d_req_t     o_req,
    output logic             o_req_val,
    input  wire logic        i_req_rdy,
    output logic             o_id_select
);

    typedef enum logic [2:0] {
        ST_WAIT_INIT,     // first d2h from device
        ST_SEND_ID,
        ST_WAIT_PIO,
        ST_WAIT_ID_DATA,
        ST_READY,
        ST_CHECK,         // fault rule on captured command
        ST_SEND_RD,
        ST_WAIT_RD        // d2h closing one transfer
    } state_t;

    state_t      state;
    state_t      nstate;
    logic        accept;
    logic        trans_done;   // transfer closed without error
    logic        fault_set;
    logic [47:0] addr_q;       // lba of next transfer
    logic [48:0] end_q;        // addr + size, one bit wider
    logic        zero_q;
    logic [16:0] count_q;      // sectors in next transfer
    logic [32:0] xfer_cnt;     // transfers left

    assign accept      = i_cmd_valid & o_cmd_ready;
    assign o_id_select = (state == ST_WAIT_PIO) | (state == ST_WAIT_ID_DATA);

    // ------------------------------------------------------------------------
    // next state and request
    always_comb begin
        nstate        = state;
        o_req_val     = 1'b0;
        o_req.command = `SATA_CMD_READ_DMA_EXT;
        o_req.lba     = addr_q;
        o_req.count   = count_q[15:0];   // 65536 goes out as 0
        trans_done    = 1'b0;
        fault_set     = 1'b0;
        case (state)
            ST_WAIT_INIT: if (i_reg_done) nstate = ST_SEND_ID;
            ST_SEND_ID: begin
                o_req_val     = 1'b1;
                o_req.command = `SATA_CMD_IDENTIFY;
                o_req.lba     = '0;
                o_req.count   = '0;
                if (i_req_rdy)
                    nstate = ST_WAIT_PIO;
            end
            ST_WAIT_PIO:     if (i_reg_done) nstate = ST_WAIT_ID_DATA;
            ST_WAIT_ID_DATA: if (i_info_valid) nstate = ST_READY;
            ST_READY:        if (accept) nstate = ST_CHECK;
            ST_CHECK: begin
                if (zero_q | (end_q > {1'b0, i_max_lba})) begin
                    fault_set = 1'b1;   // refused, nothing sent
                    nstate    = ST_READY;
                end else begin
                    nstate = ST_SEND_RD;
                end
            end
            ST_SEND_RD: begin
                o_req_val = 1'b1;
                if (i_req_rdy)
                    nstate = ST_WAIT_RD;
            end
            ST_WAIT_RD: begin
                if (i_reg_done) begin
                    if (i_reg_err) begin
                        fault_set = 1'b1;
                        nstate    = ST_READY;
                    end else begin
                        trans_done = 1'b1;
                        nstate     = (xfer_cnt == 33'd1) ? ST_READY : ST_SEND_RD;
                    end
                end
            end
            default: nstate = ST_WAIT_INIT;
        endcase
    end

    // ------------------------------------------------------------------------
    // state, handshake flags, transfer counter
    always_ff @(posedge i_usr_reset or posedge i_usr_clk) begin
        if (i_usr_clk) begin
            state       <= ST_WAIT_INIT;
            o_cmd_ready <= 1'b0;
            o_cmd_fault <= 1'b0;
            xfer_cnt    <= '0;
        end else begin
            state       <= nstate;
            o_cmd_ready <= (state == ST_READY) & ~accept;   // one cycle after entry
            if (accept)
                o_cmd_fault <= 1'b0;
            else if (fault_set)
                o_cmd_fault <= 1'b1;
            if (accept)
                xfer_cnt <= {1'b0, i_cmd.size[47:16]} + 33'(i_cmd.size[15:0] != 16'd0);
            else if (trans_done)
                xfer_cnt <= xfer_cnt - 33'd1;
        end
    end

    // command fields, address walk
    always_ff @(posedge i_usr_reset) begin
        if (accept) begin
            addr_q  <= i_cmd.addr;
            end_q   <= {1'b0, i_cmd.addr} + {1'b0, i_cmd.size};
            zero_q  <= (i_cmd.size == 48'd0);
            count_q <= {(i_cmd.size[15:0] == 16'd0), i_cmd.size[15:0]};  // rem 0 -> 65536
        end else if (trans_done) begin
            addr_q  <= addr_q + 48'(count_q);
            count_q <= `SATA_MAX_DMA_BURST;   // all later transfers full
        end
    end

endmodule

`default_nettype wire

//--- source/sata_dma_engine.sv
/*
    SATA host DMA engine, read direction
    start-up identify, user read commands, payload to the read stream
*/
`default_nettype none

module sata_dma_engine import sata_fis_pkg::*, sata_cmd_pkg::*; (
    input  wire logic         i_usr_reset,   // clock
    input  wire logic         i_usr_clk,     // async reset, active high
    input  wire logic         i_cmd_valid,
    input  wire usr_cmd_t     i_cmd,
    output logic              o_cmd_ready,
    output logic              o_cmd_fault,
    output logic              o_info_valid,
    output usr_info_t         o_info,
    output fis_tx_beat_t      o_tx,          // to link layer
    input  wire logic         i_tx_rdy,
    input  wire fis_rx_beat_t i_rx,          // from link layer
    output logic              o_rx_rdy,
    output fis_rx_beat_t      o_rd,          // user read stream
    input  wire logic         i_rd_rdy
);

    reg_h2d_req_t req;
    logic         req_val;
    logic         req_rdy;
    logic         reg_done;
    logic         reg_err;
    logic         id_select;
    fis_rx_beat_t id_beat;   // identify payload

    sata_dma_sequencer u_sequencer (
        .i_usr_reset  (i_usr_reset),
        .i_usr_clk    (i_usr_clk),
        .i_cmd_valid  (i_cmd_valid),
        .i_cmd        (i_cmd),
        .o_cmd_ready  (o_cmd_ready),
        .o_cmd_fault  (o_cmd_fault),
        .i_info_valid (o_info_valid),
        .i_max_lba    (o_info.max_lba),
        .i_reg_done   (reg_done),
        .i_reg_err    (reg_err),
        .o_req        (req),
        .o_req_val    (req_val),
        .i_req_rdy    (req_rdy),
        .o_id_select  (id_select)
    );

    sata_reg_fis_sender u_sender (
        .i_usr_reset (i_usr_reset),
        .i_usr_clk   (i_usr_clk),
        .i_req       (req),
        .i_req_val   (req_val),
        .o_req_rdy   (req_rdy),
        .o_tx        (o_tx),
        .i_tx_rdy    (i_tx_rdy)
    );

    sata_fis_router u_router (
        .i_usr_reset (i_usr_reset),
        .i_usr_clk   (i_usr_clk),
        .i_rx        (i_rx),
        .o_rx_rdy    (o_rx_rdy),
        .i_id_select (id_select),
        .o_rd        (o_rd),
        .i_rd_rdy    (i_rd_rdy),
        .o_id        (id_beat),
        .o_reg_done  (reg_done),
        .o_reg_err   (reg_err)
    );

    sata_identify_parser u_parser (
        .i_usr_reset  (i_usr_reset),
        .i_usr_clk    (i_usr_clk),
        .i_id         (id_beat),
        .o_info_valid (o_info_valid),
        .o_info       (o_info)
    );

endmodule

`default_nettype wire

//--- testbench/sata_dma_engine_assertions.sv
/*
    SATA DMA engine protocol assertions
    stream stability, transmit framing, info flag and reset values
*/
`default_nettype none

module sata_dma_engine_assertions import sata_fis_pkg::*; (
    input wire logic         i_usr_reset,   // clock
    input wire logic         i_usr_clk,     // reset
    input wire logic         o_cmd_ready,
    input wire logic         o_cmd_fault,
    input wire logic         o_info_valid,
    input wire fis_tx_beat_t o_tx,
    input wire logic         i_tx_rdy,
    input wire fis_rx_beat_t o_rd,
    input wire logic         i_rd_rdy
);

    // held beats under back-pressure
    a_tx_stable: assert property (@(posedge i_usr_reset) disable iff (i_usr_clk)
        o_tx.val && !i_tx_rdy |=> o_tx.val && $stable(o_tx.dat) && $stable(o_tx.eop))
        else $error("transmit beat changed while not accepted");

    a_rd_stable: assert property (@(posedge i_usr_reset) disable iff (i_usr_clk)
        o_rd.val && !i_rd_rdy |=> o_rd.val && $stable(o_rd.dat) && $stable(o_rd.eop))
        else $error("read beat changed while not accepted");

    // a frame keeps going until its eop beat moves
    a_tx_until_eop: assert property (@(posedge i_usr_reset) disable iff (i_usr_clk)
        o_tx.val && i_tx_rdy && !o_tx.eop |=> o_tx.val)
        else $error("transmit frame ended without eop");

    a_info_hold: assert property (@(posedge i_usr_reset) disable iff (i_usr_clk)
        o_info_valid |=> o_info_valid)
        else $error("info valid fell");

    // reset values
    a_reset_idle: assert property (@(posedge i_usr_reset)
        i_usr_clk && $past(i_usr_clk) |-> !o_cmd_ready && !o_cmd_fault && !o_tx.val)
        else $error("outputs active during reset");

    a_reset_exit: assert property (@(posedge i_usr_reset)
        $fell(i_usr_clk) |-> !o_cmd_ready && !o_cmd_fault)
        else $error("ready or fault high right after reset");

endmodule

bind sata_dma_engine sata_dma_engine_assertions u_assertions (
    .i_usr_reset  (i_usr_reset),
    .i_usr_clk    (i_usr_clk),
    .o_cmd_ready  (o_cmd_ready),
    .o_cmd_fault  (o_cmd_fault),
    .o_info_valid (o_info_valid),
    .o_tx         (o_tx),
    .i_tx_rdy     (i_tx_rdy),
    .o_rd         (o_rd),
    .i_rd_rdy     (i_rd_rdy)
);

`default_nettype wire

//--- testbench/sata_dma_engine_tb.sv
/*
    SATA DMA engine testbench
    device model replaying file stimulus, stream monitors, checker, watchdog
*/
`include "sata_config.svh"

`default_nettype none

module sata_dma_engine_tb import sata_fis_pkg::*, sata_cmd_pkg::*; ();

    localparam int CLK_HALF     = 20;
    localparam int WATCHDOG_CYC = 200000;   // per stimulus record
    localparam int MAX_REC      = 64;
    localparam int MAX_PAY      = 16;

    logic         usr_reset = 1'b0;   // clock
    logic         usr_clk   = 1'b1;   // reset, active high
    logic         cmd_valid = 1'b0;
    usr_cmd_t     cmd       = '0;
    logic         cmd_ready;
    logic         cmd_fault;
    logic         info_valid;
    usr_info_t    info;
    fis_tx_beat_t tx;
    logic         tx_rdy    = 1'b0;
    fis_rx_beat_t rx        = '0;
    logic         rx_rdy;
    fis_rx_beat_t rd;
    logic         rd_rdy    = 1'b0;

    integer       seed = 87980;

    // stimulus records loaded at time zero
    logic [7:0]   rec_kind [0:MAX_REC-1];
    logic [47:0]  rec_a    [0:MAX_REC-1];
    logic [47:0]  rec_b    [0:MAX_REC-1];
    logic [47:0]  rec_c    [0:MAX_REC-1];
    logic [31:0]  rec_pay  [0:MAX_REC-1][0:MAX_PAY-1];
    int           n_rec  = 0;
    logic         loaded = 1'b0;

    // device model state
    usr_info_t    dev_info;
    logic [31:0]  pay [0:MAX_PAY-1];   // payload of every data frame
    int           pay_n     = 0;
    logic         dev_err   = 1'b0;    // next command answered with ERR
    logic [31:0]  tx_q [$];
    logic [33:0]  rd_q [$];            // {err, eop, dat}
    int           tx_frames = 0;       // complete frames seen on o_tx
    int           tx_seen   = 0;       // frames already checked

    sata_dma_engine uut (
        .i_usr_reset  (usr_reset),
        .i_usr_clk    (usr_clk),
        .i_cmd_valid  (cmd_valid),
        .i_cmd        (cmd),
        .o_cmd_ready  (cmd_ready),
        .o_cmd_fault  (cmd_fault),
        .o_info_valid (info_valid),
        .o_info       (info),
        .o_tx         (tx),
        .i_tx_rdy     (tx_rdy),
        .i_rx         (rx),
        .o_rx_rdy     (rx_rdy),
        .o_rd         (rd),
        .i_rd_rdy     (rd_rdy)
    );

    always #CLK_HALF usr_reset = ~usr_reset;

    always @(negedge usr_reset) begin
        tx_rdy = (($random(seed) & 3) != 0);   // about one gap in four
        rd_rdy = (($random(seed) & 3) != 0);
    end

    // ------------------------------------------------------------------------
    // stream monitors for beats that moved on this edge
    always @(posedge usr_reset) begin
        if (tx.val && tx_rdy) begin
            tx_q.push_back(tx.dat);
            if (tx.eop)
                tx_frames++;
        end
        if (rd.val && rd_rdy)
            rd_q.push_back({rd.err, rd.eop, rd.dat});
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp)
            fail_run($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic load_stimulus();
        int            fd;
        int            code;
        int            n;
        logic [63:0]   tok;
        logic [1599:0] line;
        logic [47:0]   a;
        logic [47:0]   b;
        logic [47:0]   c;
        logic [31:0]   w;
        fd = $fopen("testbench/sata_dma_stimulus.txt", "r");
        if (fd == 0)
            fail_run("cannot open testbench/sata_dma_stimulus.txt");
        else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok[7:0] == "#") begin
                    code = $fgets(line, fd);   // rest of comment line
                end else begin
                    a = '0;
                    b = '0;
                    c = '0;
                    case (tok[7:0])
                        "I": code = $fscanf(fd, "%h %h", a, b);
                        "C": code = $fscanf(fd, "%h %h %h", a, b, c);
                        "E": code = $fscanf(fd, "%h", a);
                        "P": begin
                            code = $fscanf(fd, "%d", n);   // decimal word count
                            a    = 48'(n);
                            for (int i = 0; i < n; i++) begin
                                code = $fscanf(fd, "%h", w);
                                rec_pay[n_rec][i] = w;
                            end
                        end
                        default: code = 0;
                    endcase
                    rec_kind[n_rec] = tok[7:0];
                    rec_a[n_rec]    = a;
                    rec_b[n_rec]    = b;
                    rec_c[n_rec]    = c;
                    n_rec++;
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;
    endtask

    // ------------------------------------------------------------------------
    // device side of the link
    task automatic send_beat(input logic [31:0] word, input logic eop, input logic err);
        logic taken;
        @(negedge usr_reset);
        rx.dat = word;
        rx.val = 1'b1;
        rx.eop = eop;
        rx.err = err;
        taken  = 1'b0;
        while (!taken) begin   // held until rdy
            @(posedge usr_reset);
            taken = rx_rdy;
        end
    endtask

    task automatic idle_rx();
        @(negedge usr_reset);
        rx.val = 1'b0;
        rx.eop = 1'b0;
    endtask

    // register d2h or pio setup of five dwords
    task automatic send_reg_frame(input logic [7:0] fis_type, input logic err_bit);
        fis_dw0_u hdr;
        hdr.reg_hdr.fis_type = fis_type;
        hdr.reg_hdr.flags    = 8'h40;   // interrupt
        hdr.reg_hdr.status   = 8'h50 | (8'(err_bit) << `SATA_STATUS_ERR_BIT);  // drdy, dsc
        hdr.reg_hdr.error    = err_bit ? 8'h04 : 8'h00;   // abort
        send_beat(hdr, 1'b0, 1'b0);
        for (int i = 1; i < 5; i++)
            send_beat(32'h0, i == 4, 1'b0);
        idle_rx();
    endtask

    task automatic send_payload();
        send_beat({24'h0, `SATA_FIS_DATA}, 1'b0, 1'b0);   // header is never forwarded
        for (int i = 0; i < pay_n; i++)
            send_beat(pay[i], i == pay_n - 1, 1'b0);
        idle_rx();
    endtask

    // identify dword with fill tagged by full index
    function automatic logic [31:0] id_word(input int idx);
        if (idx == `SATA_ID_SATA_CAP_DW)
            return {16'hBEEF, 12'h000, dev_info.sata_supported, 1'b0};   // word 76
        if (idx == `SATA_ID_MAX_LBA_DW)
            return dev_info.max_lba[31:0];
        if (idx == `SATA_ID_MAX_LBA_DW + 1)
            return {16'hDEAD, dev_info.max_lba[47:32]};   // word 103 ignored
        return {8'hA5, 8'(idx), ~8'(idx), 8'(idx * 3)};
    endfunction

    task automatic check_h2d(input logic [7:0] command, input logic [47:0] lba,
                             input logic [15:0] count);
        logic [31:0] exp_dw [0:4];
        logic [31:0] got;
        exp_dw[0] = {8'h00, command, 8'h80, `SATA_FIS_REG_H2D};   // C bit in flags
        exp_dw[1] = {8'h40, lba[23:0]};
        exp_dw[2] = {8'h00, lba[47:24]};
        exp_dw[3] = {16'h0000, count};
        exp_dw[4] = 32'h0;
        wait (tx_frames > tx_seen);
        for (int i = 0; i < `SATA_REG_H2D_DWORDS; i++) begin
            got = tx_q.pop_front();
            check_value($sformatf("o_tx.dat frame %0d dword %0d", tx_seen, i), got, exp_dw[i]);
        end
        tx_seen++;
    endtask

    task automatic wait_ready();
        do @(negedge usr_reset); while (!cmd_ready);
    endtask

    // ------------------------------------------------------------------------
    // test sequences
    task automatic run_startup();
        send_reg_frame(`SATA_FIS_REG_D2H, 1'b0);   // device signature
        check_h2d(`SATA_CMD_IDENTIFY, 48'h0, 16'h0);
        send_reg_frame(`SATA_FIS_PIO_SETUP, 1'b0);
        send_beat({24'h0, `SATA_FIS_DATA}, 1'b0, 1'b0);
        for (int i = 0; i < `SATA_ID_DWORDS; i++)
            send_beat(id_word(i), i == `SATA_ID_DWORDS - 1, 1'b0);
        idle_rx();
        do @(negedge usr_reset); while (!info_valid);
        check_value("o_info.max_lba", info.max_lba, dev_info.max_lba);
        check_value("o_info.sata_supported", info.sata_supported, dev_info.sata_supported);
        wait_ready();
    endtask

    task automatic run_command(input logic [47:0] addr, input logic [47:0] size,
                               input logic exp_fault);
        logic [47:0] lba;
        logic [16:0] count;
        int          n_xfer;
        int          sent;
        logic [33:0] beat;
        lba    = addr;
        count  = ((size % 65536) == 0) ? 17'd65536 : 17'(size % 65536);   // first transfer
        n_xfer = int'((longint'(size) + 65535) / 65536);
        sent   = 0;
        rd_q.delete();
        wait_ready();
        cmd.addr  = addr;
        cmd.size  = size;
        cmd_valid = 1'b1;
        @(negedge usr_reset);
        cmd_valid = 1'b0;   // taken on the edge between
        if (size != 0 && longint'(addr) + longint'(size) <= longint'(dev_info.max_lba)) begin
            for (int t = 0; t < n_xfer; t++) begin
                check_h2d(`SATA_CMD_READ_DMA_EXT, lba, count[15:0]);   // 65536 as 0
                sent++;
                send_payload();
                send_reg_frame(`SATA_FIS_REG_D2H, dev_err);
                if (dev_err)
                    break;
                lba   = lba + 48'(count);
                count = 17'd65536;
            end
        end
        wait_ready();
        check_value("o_cmd_fault", cmd_fault, exp_fault);
        check_value("o_tx frame count", tx_frames, tx_seen);
        check_value("o_rd word count", rd_q.size(), sent * pay_n);
        for (int t = 0; t < sent; t++) begin
            for (int i = 0; i < pay_n; i++) begin
                beat = rd_q.pop_front();
                check_value("o_rd.dat", beat[31:0], pay[i]);
                check_value("o_rd.eop", beat[32], i == pay_n - 1);
                check_value("o_rd.err", beat[33], 1'b0);
            end
        end
        dev_err = 1'b0;
    endtask

    initial begin
        wait (loaded);
        #(longint'(n_rec) * WATCHDOG_CYC * 2 * CLK_HALF);
        fail_run("watchdog expired before the stimulus finished");
    end

    initial begin
        load_stimulus();
        repeat (4) @(posedge usr_reset);
        @(negedge usr_reset);
        usr_clk = 1'b0;   // reset released
        for (int r = 0; r < n_rec; r++) begin
            case (rec_kind[r])
                "I": begin
                    dev_info.max_lba        = rec_a[r];
                    dev_info.sata_supported = rec_b[r][2:0];
                    run_startup();
                end
                "P": begin
                    pay_n = int'(rec_a[r]);
                    for (int i = 0; i < MAX_PAY; i++)
                        pay[i] = rec_pay[r][i];
                end
                "E": dev_err = rec_a[r][0];
                "C": run_command(rec_a[r], rec_b[r], rec_c[r][0]);
                default: fail_run("unknown record kind in stimulus file");
            endcase
        end
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/sata_dma_stimulus.txt
# records: I max_lba sata_supported | P word_count(dec) words | E device_err
# C addr size expected_fault, all values hex except the P word count
I 12345678 7
P 4 0badc0de 11223344 55667788 99aabbcc
# single transfers
C 100 8 0
C 3000 ffff 0
# split transfers, remainder and full bursts
C 2000 20003 0
C 40000 20000 0
C 0 10000 0
P 1 cafef00d
# refused commands
C 500 0 1
C 12345600 79 1
# ends exactly on max lba
C 12345600 78 0
# device error on first transfer
E 1
C 1000 10010 1
# fault clears on next command
P 6 00000001 00000002 00000004 00000008 80000000 7fffffff
C 10 1 0
C 12300000 10001 0

//--- sim.f
+incdir+source
source/sata_fis_pkg.sv
source/sata_cmd_pkg.sv
source/sata_reg_fis_sender.sv
source/sata_fis_router.sv
source/sata_identify_parser.sv
source/sata_dma_sequencer.sv
source/sata_dma_engine.sv
testbench/sata_dma_engine_assertions.sv
testbench/sata_dma_engine_tb.sv

//--- Makefile
# Verilator simulation of the SATA DMA engine
# run from the project root; exit status reports pass or fail

VERILATOR ?= verilator
TOP       ?= sata_dma_engine_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP)

clean:
	rm -rf $(OBJ_DIR)

.PHONY: sim clean
